// ==== hdl/mirror_pad_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared widths and helpers for the mirror-padding DMA
// Matrix indices are 6 bits, so the source width W stays even and <= 62
// AXI bursts are INCR with 4-byte beats and all byte lanes enabled
////////////////////////////////////////////////////////////////////////////

package mirror_pad_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [5:0]        coord_t;  // Matrix index 0..63
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    localparam int ELEM_BYTES  = 4;
    localparam int BLOCK_BEATS = 4;                 // Words in one 2x2 block
    localparam int ROW_BEATS   = BLOCK_BEATS / 2;   // Words in one block row

    // Padded index to 1-based source index
    // Row/column 0 folds onto 1, W+1 folds onto W
    function automatic coord_t mirror_idx(coord_t p, coord_t w);
        if (p == '0) begin
            return coord_t'(1);
        end else if (p == w + coord_t'(1)) begin
            return w;
        end else begin
            return p;
        end
    endfunction

    // Byte address of a row-major element, stride counted in elements
    function automatic addr_t elem_addr(
        addr_t  base,
        coord_t row,
        coord_t col,
        addr_t  stride
    );
        return base + (addr_t'(row) * stride + addr_t'(col)) * addr_t'(ELEM_BYTES);
    endfunction

endpackage

// ==== hdl/block_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Block handoff between sequencer, reader and writer
// fetch, tile_valid and block_done are single-cycle pulses
////////////////////////////////////////////////////////////////////////////

interface block_if;
    import mirror_pad_pkg::*;

    coord_t block_row;   // Top-left corner of the 2x2 block, padded coords
    coord_t block_col;
    coord_t width;       // Source width W
    addr_t  src_base;
    addr_t  dst_base;
    logic   fetch;
    logic   block_done;

    modport seq    (output block_row, block_col, width, src_base, dst_base, fetch,
                    input  block_done);
    modport reader (input  block_row, block_col, width, src_base, fetch);
    modport writer (input  block_row, block_col, width, dst_base,
                    output block_done);
endinterface

interface tile_if;
    import mirror_pad_pkg::*;

    // Words hold until the next fetch
    data_t tl;
    data_t tr;
    data_t bl;
    data_t br;
    logic  tile_valid;

    modport src (output tl, tr, bl, br, tile_valid);
    modport dst (input  tl, tr, bl, br, tile_valid);
endinterface

// ==== hdl/block_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Job control and block walk over the (W+2)x(W+2) padded matrix
// Widths above MAX_WIDTH are clamped, odd widths are not supported
// After a job, start_i must drop before the next one is accepted
////////////////////////////////////////////////////////////////////////////

module block_sequencer #(
    parameter int MAX_WIDTH = 62
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  mirror_pad_pkg::addr_t  src_addr_i,
    input  mirror_pad_pkg::addr_t  dst_addr_i,
    input  mirror_pad_pkg::coord_t mat_width_i,
    output logic                   done_o,
    block_if.seq                   blk
);
    import mirror_pad_pkg::*;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_RUN    = 2'd1;
    localparam logic [1:0] S_FINISH = 2'd2;

    localparam coord_t WIDTH_LIMIT = coord_t'(MAX_WIDTH);

    logic [1:0] state_q;
    logic       fetch_q;
    logic       done_q;
    coord_t     row_q;
    coord_t     col_q;
    coord_t     width_q;
    addr_t      src_q;
    addr_t      dst_q;
    logic       last_block;

    // Blocks start at even padded indices, the last one sits at (W, W)
    assign last_block = (row_q == width_q) && (col_q == width_q);

    assign blk.block_row = row_q;
    assign blk.block_col = col_q;
    assign blk.width     = width_q;
    assign blk.src_base  = src_q;
    assign blk.dst_base  = dst_q;
    assign blk.fetch     = fetch_q;
    assign done_o        = done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            fetch_q <= 1'b0;
            done_q  <= 1'b1;
            row_q   <= '0;
            col_q   <= '0;
        end else begin
            fetch_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_RUN;
                        done_q  <= 1'b0;
                        row_q   <= '0;
                        col_q   <= '0;
                        fetch_q <= 1'b1;   // First block right away
                    end
                end
                S_RUN: begin
                    if (blk.block_done) begin
                        if (last_block) begin
                            state_q <= S_FINISH;
                            done_q  <= 1'b1;
                        end else begin
                            fetch_q <= 1'b1;
                            // Wrap to the next block row after column W
                            if (col_q == width_q) begin
                                col_q <= '0;
                                row_q <= row_q + coord_t'(2);
                            end else begin
                                col_q <= col_q + coord_t'(2);
                            end
                        end
                    end
                end
                S_FINISH: begin
                    if (!start_i) state_q <= S_IDLE;   // Wait for start release
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Job settings captured on start
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start_i) begin
            src_q   <= src_addr_i;
            dst_q   <= dst_addr_i;
            width_q <= (mat_width_i > WIDTH_LIMIT) ? WIDTH_LIMIT : mat_width_i;
        end
    end

endmodule

// ==== hdl/tile_reader.sv ====
////////////////////////////////////////////////////////////////////////////
// Reads the source words of one 2x2 block, one AXI burst per source row
// Only one burst is outstanding; the second AR waits for the first rlast
////////////////////////////////////////////////////////////////////////////

module tile_reader (
    input  logic                  clk,
    input  logic                  rst_n,
    block_if.reader               blk,
    tile_if.src                   tile,
    output mirror_pad_pkg::addr_t araddr_o,
    output logic [3:0]            arlen_o,
    output logic                  arvalid_o,
    input  logic                  arready_i,
    input  mirror_pad_pkg::data_t rdata_i,
    input  logic                  rlast_i,
    input  logic                  rvalid_i,
    output logic                  rready_o
);
    import mirror_pad_pkg::*;

    localparam logic [1:0] R_IDLE = 2'd0;
    localparam logic [1:0] R_ADDR = 2'd1;
    localparam logic [1:0] R_DATA = 2'd2;

    logic [1:0] state_q;
    logic       burst_q;        // Which source row is in flight
    logic       beat_q;         // Beat within the row burst
    logic       valid_q;
    logic       two_rows_q;
    logic       two_cols_q;
    addr_t      ar_addr_q;
    addr_t      next_addr_q;    // Start of the second source row
    data_t      buf_q [2][2];

    coord_t r0, r1, c0, c1;     // Mirrored 1-based source indices
    logic   two_rows;
    logic   two_cols;

    assign r0 = mirror_idx(blk.block_row, blk.width);
    assign r1 = mirror_idx(blk.block_row + coord_t'(1), blk.width);
    assign c0 = mirror_idx(blk.block_col, blk.width);
    assign c1 = mirror_idx(blk.block_col + coord_t'(1), blk.width);

    // A border block folds onto a single source row or column
    assign two_rows = (r0 != r1);
    assign two_cols = (c0 != c1);

    assign araddr_o  = ar_addr_q;
    assign arlen_o   = two_cols_q ? 4'(ROW_BEATS - 1) : 4'd0;
    assign arvalid_o = (state_q == R_ADDR);
    assign rready_o  = (state_q == R_DATA);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= R_IDLE;
            burst_q <= 1'b0;
            beat_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                R_IDLE: begin
                    if (blk.fetch) begin
                        state_q <= R_ADDR;
                        burst_q <= 1'b0;
                        beat_q  <= 1'b0;
                    end
                end
                R_ADDR: if (arready_i) state_q <= R_DATA;
                R_DATA: begin
                    if (rvalid_i) begin
                        beat_q <= ~beat_q;
                        if (rlast_i) begin
                            beat_q  <= 1'b0;
                            burst_q <= 1'b1;
                            if (!burst_q && two_rows_q) begin
                                state_q <= R_ADDR;   // Second source row
                            end else begin
                                state_q <= R_IDLE;
                                valid_q <= 1'b1;
                            end
                        end
                    end
                end
                default: state_q <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == R_IDLE && blk.fetch) begin
            two_rows_q  <= two_rows;
            two_cols_q  <= two_cols;
            ar_addr_q   <= elem_addr(blk.src_base, r0 - coord_t'(1), c0 - coord_t'(1),
                                     addr_t'(blk.width));
            next_addr_q <= elem_addr(blk.src_base, r1 - coord_t'(1), c0 - coord_t'(1),
                                     addr_t'(blk.width));
        end else if (state_q == R_DATA && rvalid_i) begin
            buf_q[burst_q][beat_q] <= rdata_i;
            if (rlast_i) ar_addr_q <= next_addr_q;
        end
    end

    // Folded positions reuse the single fetched row or column
    assign tile.tl         = buf_q[0][0];
    assign tile.tr         = buf_q[0][two_cols_q];
    assign tile.bl         = buf_q[two_rows_q][0];
    assign tile.br         = buf_q[two_rows_q][two_cols_q];
    assign tile.tile_valid = valid_q;

endmodule

// ==== hdl/tile_writer.sv ====
////////////////////////////////////////////////////////////////////////////
// Writes one 2x2 block as two 2-beat bursts, one per padded row
// Each burst waits for its write response before the next AW
////////////////////////////////////////////////////////////////////////////

module tile_writer (
    input  logic                  clk,
    input  logic                  rst_n,
    block_if.writer               blk,
    tile_if.dst                   tile,
    output mirror_pad_pkg::addr_t awaddr_o,
    output logic [3:0]            awlen_o,
    output logic                  awvalid_o,
    input  logic                  awready_i,
    output mirror_pad_pkg::data_t wdata_o,
    output logic                  wlast_o,
    output logic                  wvalid_o,
    input  logic                  wready_i,
    input  logic                  bvalid_i,
    output logic                  bready_o
);
    import mirror_pad_pkg::*;

    localparam logic [1:0] W_IDLE = 2'd0;
    localparam logic [1:0] W_ADDR = 2'd1;
    localparam logic [1:0] W_DATA = 2'd2;
    localparam logic [1:0] W_RESP = 2'd3;

    logic [1:0] state_q;
    logic [2:0] beat_q;                 // Beats sent so far in this block
    logic       done_q;
    addr_t      aw_addr_q;
    data_t      word_q [BLOCK_BEATS];   // tl, tr, bl, br
    addr_t      stride;

    assign stride = addr_t'(blk.width) + addr_t'(2);   // Padded row length

    assign awaddr_o  = aw_addr_q;
    assign awlen_o   = 4'(ROW_BEATS - 1);
    assign awvalid_o = (state_q == W_ADDR);
    assign wvalid_o  = (state_q == W_DATA);
    assign wdata_o   = word_q[beat_q[1:0]];
    assign wlast_o   = wvalid_o && beat_q[0];   // Second beat of each row
    assign bready_o  = (state_q == W_RESP);

    assign blk.block_done = done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= W_IDLE;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                W_IDLE: begin
                    if (tile.tile_valid) begin
                        state_q <= W_ADDR;
                        beat_q  <= '0;
                    end
                end
                W_ADDR: if (awready_i) state_q <= W_DATA;
                W_DATA: begin
                    if (wready_i) begin
                        beat_q <= beat_q + 3'd1;
                        if (beat_q[0]) state_q <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (bvalid_i) begin
                        if (beat_q == 3'(BLOCK_BEATS)) begin
                            state_q <= W_IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= W_ADDR;   // Bottom row of the block
                        end
                    end
                end
                default: state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == W_IDLE && tile.tile_valid) begin
            word_q[0] <= tile.tl;
            word_q[1] <= tile.tr;
            word_q[2] <= tile.bl;
            word_q[3] <= tile.br;
            aw_addr_q <= elem_addr(blk.dst_base, blk.block_row, blk.block_col, stride);
        end else if (state_q == W_RESP && bvalid_i) begin
            aw_addr_q <= elem_addr(blk.dst_base, blk.block_row + coord_t'(1),
                                   blk.block_col, stride);
        end
    end

endmodule

// ==== hdl/mirror_pad_dma.sv ====
////////////////////////////////////////////////////////////////////////////
// Mirror-padding DMA top with plain AXI master ports
// IDs, size, burst type, strobes and response codes are not brought out
// Bursts are INCR with 4-byte beats, one block in flight at a time
////////////////////////////////////////////////////////////////////////////

module mirror_pad_dma #(
    parameter int MAX_WIDTH = 62
) (
    input  logic                   clk,
    input  logic                   rst_n,

    input  mirror_pad_pkg::addr_t  src_addr_i,
    input  mirror_pad_pkg::addr_t  dst_addr_i,
    input  mirror_pad_pkg::coord_t mat_width_i,
    input  logic                   start_i,
    output logic                   done_o,

    // AR channel
    output mirror_pad_pkg::addr_t  araddr_o,
    output logic [3:0]             arlen_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,

    // R channel
    input  mirror_pad_pkg::data_t  rdata_i,
    input  logic                   rlast_i,
    input  logic                   rvalid_i,
    output logic                   rready_o,

    // AW channel
    output mirror_pad_pkg::addr_t  awaddr_o,
    output logic [3:0]             awlen_o,
    output logic                   awvalid_o,
    input  logic                   awready_i,

    // W channel
    output mirror_pad_pkg::data_t  wdata_o,
    output logic                   wlast_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,

    // B channel
    input  logic                   bvalid_i,
    output logic                   bready_o
);

    block_if blk ();
    tile_if  tile ();

    block_sequencer #(
        .MAX_WIDTH (MAX_WIDTH)
    ) u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .mat_width_i (mat_width_i),
        .done_o      (done_o),
        .blk         (blk.seq)
    );

    tile_reader u_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk       (blk.reader),
        .tile      (tile.src),
        .araddr_o  (araddr_o),
        .arlen_o   (arlen_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rdata_i   (rdata_i),
        .rlast_i   (rlast_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o)
    );

    tile_writer u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk       (blk.writer),
        .tile      (tile.dst),
        .awaddr_o  (awaddr_o),
        .awlen_o   (awlen_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wlast_o   (wlast_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o)
    );

endmodule

// ==== tb/axi_mem_model.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI slave memory, word addressed, one read and one write burst at a time
// Outputs change on the falling edge, handshakes are taken on the rising one
////////////////////////////////////////////////////////////////////////////

module axi_mem_model #(
    parameter int          MEM_WORDS = 1024,
    parameter logic [31:0] SEED      = 32'h70c7_c0fa
) (
    input  logic        clk,
    input  logic [31:0] rd_lo_i,     // Allowed read window, byte addresses
    input  logic [31:0] rd_hi_i,
    input  logic [31:0] araddr_i,
    input  logic [3:0]  arlen_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic        rlast_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    input  logic [31:0] awaddr_i,
    input  logic [3:0]  awlen_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] wdata_i,
    input  logic        wlast_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic        bvalid_o,
    input  logic        bready_i,
    output int          wr_bursts_o,
    output int          wr_beat_errs_o,
    output int          rd_range_errs_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [MEM_WORDS];

    integer      seed;
    logic [31:0] rnd;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    int          rd_left;
    int          wr_left;
    logic        rd_busy;
    logic        aw_seen;   // Address taken, data beats pending
    logic        b_pend;
    logic        r_fire;
    logic        b_fire;

    initial begin
        seed            = SEED;
        rd_busy         = 1'b0;
        aw_seen         = 1'b0;
        b_pend          = 1'b0;
        r_fire          = 1'b0;
        b_fire          = 1'b0;
        rd_addr         = '0;
        rd_left         = 0;
        arready_o       = 1'b0;
        rdata_o         = '0;
        rlast_o         = 1'b0;
        rvalid_o        = 1'b0;
        awready_o       = 1'b0;
        wready_o        = 1'b0;
        bvalid_o        = 1'b0;
        wr_bursts_o     = 0;
        wr_beat_errs_o  = 0;
        rd_range_errs_o = 0;
    end

    always @(posedge clk) begin
        r_fire = rvalid_o && rready_i;
        b_fire = bvalid_o && bready_i;
        if (arvalid_i && arready_o) begin
            if (araddr_i < rd_lo_i || araddr_i + 4 * (arlen_i + 1) > rd_hi_i) begin
                rd_range_errs_o++;
            end
            rd_addr = araddr_i;
            rd_left = arlen_i + 1;
            rd_busy = 1'b1;
        end
        if (r_fire) begin
            rd_addr += 4;
            rd_left--;
            if (rd_left == 0) rd_busy = 1'b0;
        end
        if (awvalid_i && awready_o) begin
            if (awlen_i != 4'd1) wr_beat_errs_o++;   // Two beats per block row
            wr_addr = awaddr_i;
            wr_left = awlen_i + 1;
            aw_seen = 1'b1;
            wr_bursts_o++;
        end
        if (wvalid_i && wready_o) begin
            if (wlast_i != (wr_left == 1) || wr_addr >= 4 * MEM_WORDS) begin
                wr_beat_errs_o++;
            end else begin
                mem[wr_addr >> 2] = wdata_i;
            end
            wr_addr += 4;
            wr_left--;
            if (wr_left == 0) begin
                aw_seen = 1'b0;
                b_pend  = 1'b1;
            end
        end
        if (b_fire) b_pend = 1'b0;
    end

    // Ready about three cycles in four, valids held until taken
    always @(negedge clk) begin
        rnd       = $random(seed);
        arready_o = !rd_busy && (rnd[1:0] != 2'b00);
        awready_o = !aw_seen && !b_pend && (rnd[3:2] != 2'b00);
        wready_o  = aw_seen && (rnd[5:4] != 2'b00);
        if (!rvalid_o || r_fire) rvalid_o = rd_busy && (rnd[7:6] != 2'b00);
        if (!bvalid_o || b_fire) bvalid_o = b_pend && (rnd[9:8] != 2'b00);
        rdata_o = mem[rd_addr >> 2];
        rlast_o = (rd_left == 1);
    end

endmodule

// ==== tb/mirror_pad_dma_assertions.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI handshake and done_o rules, bound into mirror_pad_dma
////////////////////////////////////////////////////////////////////////////

module mirror_pad_dma_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input mirror_pad_pkg::addr_t araddr_o,
    input logic                  arvalid_o,
    input logic                  arready_i,
    input mirror_pad_pkg::addr_t awaddr_o,
    input logic                  awvalid_o,
    input logic                  awready_i,
    input logic                  wvalid_o,
    input logic                  wlast_o,
    input logic                  done_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // Read by the testbench at the end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else begin
            fail_count++;
            $error("arvalid_o dropped or araddr_o changed before arready_i");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
        else begin
            fail_count++;
            $error("awvalid_o dropped or awaddr_o changed before awready_i");
        end

    wlast_with_wvalid: assert property (@(posedge clk) disable iff (!rst_n)
        wlast_o |-> wvalid_o)
        else begin
            fail_count++;
            $error("wlast_o high without wvalid_o");
        end

    busy_not_done: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid_o || awvalid_o || wvalid_o) |-> !done_o)
        else begin
            fail_count++;
            $error("done_o high while a request is pending");
        end

endmodule

// ==== tb/mirror_pad_dma_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Runs a table of padding jobs against a stalling AXI memory
// Job regions must not overlap and must fit in the model's 4 KB
////////////////////////////////////////////////////////////////////////////

module mirror_pad_dma_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mirror_pad_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int NUM_JOBS  = 4;

    // Width, source base, destination base, expected write bursts
    localparam int JOB_W      [NUM_JOBS] = '{2, 4, 6, 10};
    localparam int JOB_SRC    [NUM_JOBS] = '{'h000, 'h100, 'h300, 'h600};
    localparam int JOB_DST    [NUM_JOBS] = '{'h040, 'h180, 'h400, 'h800};
    localparam int JOB_BURSTS [NUM_JOBS] = '{8, 18, 32, 72};

    logic        clk;
    logic        rst_n;
    addr_t       src_addr;
    addr_t       dst_addr;
    coord_t      mat_width;
    logic        start;
    logic        done;
    addr_t       araddr;
    logic [3:0]  arlen;
    logic        arvalid;
    logic        arready;
    data_t       rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    addr_t       awaddr;
    logic [3:0]  awlen;
    logic        awvalid;
    logic        awready;
    data_t       wdata;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [31:0] rd_lo;
    logic [31:0] rd_hi;
    int          wr_bursts;
    int          wr_beat_errs;
    int          rd_range_errs;
    integer      seed;
    data_t       expected [MEM_WORDS];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    mirror_pad_dma dut_i (
        .clk (clk), .rst_n (rst_n),
        .src_addr_i (src_addr), .dst_addr_i (dst_addr), .mat_width_i (mat_width),
        .start_i (start), .done_o (done),
        .araddr_o (araddr), .arlen_o (arlen), .arvalid_o (arvalid), .arready_i (arready),
        .rdata_i (rdata), .rlast_i (rlast), .rvalid_i (rvalid), .rready_o (rready),
        .awaddr_o (awaddr), .awlen_o (awlen), .awvalid_o (awvalid), .awready_i (awready),
        .wdata_o (wdata), .wlast_o (wlast), .wvalid_o (wvalid), .wready_i (wready),
        .bvalid_i (bvalid), .bready_o (bready)
    );

    axi_mem_model #(.MEM_WORDS (MEM_WORDS)) mem_i (
        .clk (clk), .rd_lo_i (rd_lo), .rd_hi_i (rd_hi),
        .araddr_i (araddr), .arlen_i (arlen), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rlast_o (rlast), .rvalid_o (rvalid), .rready_i (rready),
        .awaddr_i (awaddr), .awlen_i (awlen), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wlast_i (wlast), .wvalid_i (wvalid), .wready_o (wready),
        .bvalid_o (bvalid), .bready_i (bready),
        .wr_bursts_o (wr_bursts), .wr_beat_errs_o (wr_beat_errs),
        .rd_range_errs_o (rd_range_errs)
    );

    bind mirror_pad_dma mirror_pad_dma_assertions asrt_i (.*);

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Padded index to 0-based source index: edges fold onto their neighbour
    function automatic int source_index(input int p, input int w);
        if (p == 0) return 0;
        if (p == w + 1) return w - 1;
        return p - 1;
    endfunction

    function automatic int watchdog_cycles();
        int total;
        total = 100;   // Reset and start/release overhead
        for (int j = 0; j < NUM_JOBS; j++) begin
            total += 200 * (JOB_W[j] + 2) * (JOB_W[j] + 2);
        end
        return total;
    endfunction

    task automatic fill_memory();
        data_t word;
        for (int i = 0; i < MEM_WORDS; i++) begin
            word           = $random(seed);
            mem_i.mem[i]   = word;
            expected[i]    = word;
        end
    endtask

    task automatic predict_padding(input int j);
        int w;
        int src_word;
        int dst_word;
        w        = JOB_W[j];
        src_word = JOB_SRC[j] / 4;
        dst_word = JOB_DST[j] / 4;
        for (int pr = 0; pr < w + 2; pr++) begin
            for (int pc = 0; pc < w + 2; pc++) begin
                expected[dst_word + pr * (w + 2) + pc] =
                    expected[src_word + source_index(pr, w) * w + source_index(pc, w)];
            end
        end
    endtask

    task automatic run_job(input int j);
        @(negedge clk);
        src_addr  = addr_t'(JOB_SRC[j]);
        dst_addr  = addr_t'(JOB_DST[j]);
        mat_width = coord_t'(JOB_W[j]);
        rd_lo     = JOB_SRC[j];
        rd_hi     = JOB_SRC[j] + 4 * JOB_W[j] * JOB_W[j];
        start     = 1'b1;
        @(negedge clk);
        check_value("done_o", done, 1'b0);
        while (!done) @(negedge clk);   // Watchdog bounds this wait
        // Start still held, so no new job may begin
        repeat (3) begin
            @(negedge clk);
            check_value("done_o", done, 1'b1);
            check_value("arvalid_o", arvalid, 1'b0);
        end
        start = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk);
        $display("Timeout: the jobs did not finish within %0d cycles", limit);
        $display("test failed");
        $fatal(1);
    end

    initial begin
        int bursts_before;
        seed        = 32'h70c7_c0fa;
        rst_n       = 1'b0;
        start       = 1'b0;
        src_addr    = '0;
        dst_addr    = '0;
        mat_width   = '0;
        rd_lo       = '0;
        rd_hi       = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("done_o", done, 1'b1);
        check_value("arvalid_o", arvalid, 1'b0);
        check_value("rready_o", rready, 1'b0);
        check_value("awvalid_o", awvalid, 1'b0);
        check_value("wvalid_o", wvalid, 1'b0);
        check_value("bready_o", bready, 1'b0);

        for (int j = 0; j < NUM_JOBS; j++) begin
            fill_memory();
            predict_padding(j);
            bursts_before = wr_bursts;
            run_job(j);
            check_value("write bursts", wr_bursts - bursts_before, JOB_BURSTS[j]);
            check_value("wr_beat_errs", wr_beat_errs, 0);
            check_value("rd_range_errs", rd_range_errs, 0);
            for (int i = 0; i < MEM_WORDS; i++) begin
                check_value($sformatf("mem[%0d]", i), mem_i.mem[i], expected[i]);
            end
        end
        check_value("assertion failures", dut_i.asrt_i.fail_count, 0);

        $display("test passed");
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/mirror_pad_pkg.sv
hdl/block_if.sv
hdl/block_sequencer.sv
hdl/tile_reader.sv
hdl/tile_writer.sv
hdl/mirror_pad_dma.sv
tb/axi_mem_model.sv
tb/mirror_pad_dma_assertions.sv
tb/mirror_pad_dma_tb.sv

// ==== Bender.yml ====
package:
  name: mirror_pad_dma

sources:
  - files:
      - hdl/mirror_pad_pkg.sv
      - hdl/block_if.sv
      - hdl/block_sequencer.sv
      - hdl/tile_reader.sv
      - hdl/tile_writer.sv
      - hdl/mirror_pad_dma.sv
  - target: test
    files:
      - tb/axi_mem_model.sv
      - tb/mirror_pad_dma_assertions.sv
      - tb/mirror_pad_dma_tb.sv
